// File: rvfi_mon_pkg.sv
//******************************
// RVFI monitor definitions
//******************************

package rvfi_mon_pkg;

  // Rules checked on every retirement, also the counter and status bit order
  typedef enum logic [2:0] {
    RULE_RS_RESET  = 3'd0,
    RULE_DBG_CAUSE = 3'd1,
    RULE_EXC_CAUSE = 3'd2,
    RULE_IRQ_CAUSE = 3'd3,
    RULE_NO_CAUSE  = 3'd4,
    RULE_MEM_COUNT = 3'd5
  } rule_e;

  localparam int NUM_RULES = 6;
  localparam int CNT_W     = 16;

  // Interrupt cause legality
  localparam int          CLIC_ID_W     = 5;
  localparam logic [10:0] NMI_CAUSE_LO  = 11'd1024;
  localparam logic [10:0] NMI_CAUSE_HI  = 11'd1027;
  localparam int          NUM_CLINT_STD = 3;
  localparam logic [NUM_CLINT_STD-1:0][10:0] CLINT_STD_CAUSES = {11'd11, 11'd7, 11'd3};
  localparam logic [10:0] CLINT_PLAT_LO = 11'd16;
  localparam logic [10:0] CLINT_PLAT_HI = 11'd31;

  // Debug entry causes, as found in dcsr.cause
  typedef enum logic [2:0] {
    DBG_NONE    = 3'd0,
    DBG_EBREAK  = 3'd1,
    DBG_TRIGGER = 3'd2,
    DBG_HALTREQ = 3'd3,
    DBG_STEP    = 3'd4
  } dbg_cause_e;

  localparam int DCSR_CAUSE_LSB = 6;

  // AXI4-Lite register map
  localparam int AXI_AW = 6;

  typedef enum logic [AXI_AW-1:0] {
    REG_CTRL   = 6'h00,
    REG_STATUS = 6'h04,
    REG_CNT0   = 6'h08,
    REG_CNT1   = 6'h0C,
    REG_CNT2   = 6'h10,
    REG_CNT3   = 6'h14,
    REG_CNT4   = 6'h18,
    REG_CNT5   = 6'h1C
  } reg_addr_e;

  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: retire_state_check.sv
//******************************
// Retirement history checks
//******************************

`timescale 1ns/1ps

module retire_state_check import rvfi_mon_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rvfi_valid,
  input  logic [4:0]  rvfi_rs1_addr,
  input  logic [4:0]  rvfi_rs2_addr,
  input  logic [31:0] rvfi_rs1_rdata,
  input  logic [31:0] rvfi_rs2_rdata,
  input  logic [2:0]  rvfi_dbg,
  input  logic        rvfi_dbg_mode,
  input  logic [31:0] rvfi_csr_dcsr_rdata,
  output logic        viol_rs_reset,
  output logic        viol_dbg_cause
);

  logic       first_ret;
  logic       was_dbg_mode;
  logic       rs_nonzero;
  logic [2:0] dcsr_cause;

  // A source register other than x0 must still hold its reset value
  assign rs_nonzero = ((rvfi_rs1_addr != 5'd0) && (rvfi_rs1_rdata != 32'd0)) ||
                      ((rvfi_rs2_addr != 5'd0) && (rvfi_rs2_rdata != 32'd0));

  assign dcsr_cause = rvfi_csr_dcsr_rdata[DCSR_CAUSE_LSB +: 3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_ret      <= 1'b1;
      was_dbg_mode   <= 1'b0;
      viol_rs_reset  <= 1'b0;
      viol_dbg_cause <= 1'b0;
    end else begin
      viol_rs_reset  <= rvfi_valid && first_ret && rs_nonzero;
      // Only the entry into debug mode carries a fresh cause
      viol_dbg_cause <= rvfi_valid && (rvfi_dbg != DBG_NONE) && !was_dbg_mode &&
                        (rvfi_dbg != dcsr_cause);
      if (rvfi_valid) begin
        first_ret    <= 1'b0;
        was_dbg_mode <= rvfi_dbg_mode;
      end
    end
  end

endmodule

// File: trap_cause_check.sv
//******************************
// Trap cause checks
//******************************

`timescale 1ns/1ps

module trap_cause_check import rvfi_mon_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clic_en,
  input  logic        rvfi_valid,
  input  logic        rvfi_dbg_mode,
  input  logic        rvfi_exception,
  input  logic [5:0]  rvfi_exception_cause,
  input  logic [31:0] rvfi_csr_mcause_wdata,
  input  logic [31:0] rvfi_csr_mcause_wmask,
  input  logic        rvfi_intr,
  input  logic [10:0] rvfi_intr_cause,
  input  logic        rvfi_trap_debug,
  input  logic [2:0]  rvfi_debug_cause,
  output logic        viol_exc_cause,
  output logic        viol_irq_cause,
  output logic        viol_no_cause
);

  logic [10:0] mcause_code;
  logic        clint_std_hit;
  logic        nmi_hit;
  logic        irq_legal;
  logic        no_cause;

  assign mcause_code = rvfi_csr_mcause_wdata[10:0] & rvfi_csr_mcause_wmask[10:0];

  always_comb begin
    clint_std_hit = 1'b0;
    for (int i = 0; i < NUM_CLINT_STD; i++) begin
      if (rvfi_intr_cause == CLINT_STD_CAUSES[i]) begin
        clint_std_hit = 1'b1;
      end
    end
  end

  // NMI causes are legal under both controllers
  assign nmi_hit = (rvfi_intr_cause >= NMI_CAUSE_LO) && (rvfi_intr_cause <= NMI_CAUSE_HI);

  assign irq_legal = nmi_hit || (clic_en ? ((rvfi_intr_cause >> CLIC_ID_W) == 11'd0) :
                     (clint_std_hit || ((rvfi_intr_cause >= CLINT_PLAT_LO) &&
                                        (rvfi_intr_cause <= CLINT_PLAT_HI))));

  // CLIC may legally take interrupt ID 0
  assign no_cause = (rvfi_exception && (rvfi_exception_cause == 6'd0)) ||
                    (rvfi_trap_debug && (rvfi_debug_cause == DBG_NONE)) ||
                    (rvfi_intr && !clic_en && (rvfi_intr_cause == 11'd0));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_exc_cause <= 1'b0;
      viol_irq_cause <= 1'b0;
      viol_no_cause  <= 1'b0;
    end else begin
      viol_exc_cause <= rvfi_valid && rvfi_exception && !rvfi_dbg_mode &&
                        ({5'd0, rvfi_exception_cause} != mcause_code);
      viol_irq_cause <= rvfi_valid && rvfi_intr && !irq_legal;
      viol_no_cause  <= rvfi_valid && no_cause;
    end
  end

endmodule

// File: mem_count_check.sv
//******************************
// Memory access count check
//******************************

`timescale 1ns/1ps

module mem_count_check (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear,
  input  logic       rvfi_valid,
  input  logic [3:0] rvfi_mem_rmask,
  input  logic [3:0] rvfi_mem_wmask,
  input  logic       wbuf_valid,
  input  logic       wbuf_ready,
  output logic       viol_mem_count
);

  logic [31:0] bus_cnt;
  logic [31:0] ret_cnt;
  logic [1:0]  ret_inc;

  // One access each for a read and a write in the same instruction
  assign ret_inc = rvfi_valid ? ({1'b0, |rvfi_mem_rmask} + {1'b0, |rvfi_mem_wmask}) : 2'd0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_cnt        <= 32'd0;
      ret_cnt        <= 32'd0;
      viol_mem_count <= 1'b0;
    end else if (clear) begin
      bus_cnt        <= 32'd0;
      ret_cnt        <= 32'd0;
      viol_mem_count <= 1'b0;
    end else begin
      bus_cnt        <= bus_cnt + {31'd0, wbuf_valid && wbuf_ready};
      ret_cnt        <= ret_cnt + {30'd0, ret_inc};
      viol_mem_count <= ret_cnt > bus_cnt;
    end
  end

endmodule

// File: violation_log.sv
//******************************
// Violation counters
//******************************

`timescale 1ns/1ps

module violation_log import rvfi_mon_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear,
  input  logic                 viol_rs_reset,
  input  logic                 viol_dbg_cause,
  input  logic                 viol_exc_cause,
  input  logic                 viol_irq_cause,
  input  logic                 viol_no_cause,
  input  logic                 viol_mem_count,
  output logic [CNT_W-1:0]     cnt_rs_reset,
  output logic [CNT_W-1:0]     cnt_dbg_cause,
  output logic [CNT_W-1:0]     cnt_exc_cause,
  output logic [CNT_W-1:0]     cnt_irq_cause,
  output logic [CNT_W-1:0]     cnt_no_cause,
  output logic [CNT_W-1:0]     cnt_mem_count,
  output logic [NUM_RULES-1:0] status,
  output logic                 violation_o
);

  logic [NUM_RULES-1:0] viol_vec;
  logic [CNT_W-1:0]     cnt_q [NUM_RULES];

  assign viol_vec[RULE_RS_RESET]  = viol_rs_reset;
  assign viol_vec[RULE_DBG_CAUSE] = viol_dbg_cause;
  assign viol_vec[RULE_EXC_CAUSE] = viol_exc_cause;
  assign viol_vec[RULE_IRQ_CAUSE] = viol_irq_cause;
  assign viol_vec[RULE_NO_CAUSE]  = viol_no_cause;
  assign viol_vec[RULE_MEM_COUNT] = viol_mem_count;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status <= '0;
      for (int i = 0; i < NUM_RULES; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (clear) begin
      status <= '0;
      for (int i = 0; i < NUM_RULES; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      status <= status | viol_vec;
      for (int i = 0; i < NUM_RULES; i++) begin
        // Saturate at all ones
        if (viol_vec[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign cnt_rs_reset  = cnt_q[RULE_RS_RESET];
  assign cnt_dbg_cause = cnt_q[RULE_DBG_CAUSE];
  assign cnt_exc_cause = cnt_q[RULE_EXC_CAUSE];
  assign cnt_irq_cause = cnt_q[RULE_IRQ_CAUSE];
  assign cnt_no_cause  = cnt_q[RULE_NO_CAUSE];
  assign cnt_mem_count = cnt_q[RULE_MEM_COUNT];
  assign violation_o   = |status;

endmodule

// File: axil_regs.sv
//******************************
// AXI4-Lite register slave
//******************************

`timescale 1ns/1ps

module axil_regs import rvfi_mon_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 awvalid,
  output logic                 awready,
  input  logic [AXI_AW-1:0]    awaddr,
  input  logic                 wvalid,
  output logic                 wready,
  input  logic [31:0]          wdata,
  input  logic [3:0]           wstrb,
  output logic                 bvalid,
  input  logic                 bready,
  output logic [1:0]           bresp,
  input  logic                 arvalid,
  output logic                 arready,
  input  logic [AXI_AW-1:0]    araddr,
  output logic                 rvalid,
  input  logic                 rready,
  output logic [31:0]          rdata,
  output logic [1:0]           rresp,
  input  logic [NUM_RULES-1:0] status,
  input  logic [CNT_W-1:0]     cnt_rs_reset,
  input  logic [CNT_W-1:0]     cnt_dbg_cause,
  input  logic [CNT_W-1:0]     cnt_exc_cause,
  input  logic [CNT_W-1:0]     cnt_irq_cause,
  input  logic [CNT_W-1:0]     cnt_no_cause,
  input  logic [CNT_W-1:0]     cnt_mem_count,
  output logic                 clic_en,
  output logic                 clear
);

  logic             wr_accept;
  logic             rd_accept;
  logic [31:0]      rd_mux;
  logic [CNT_W-1:0] cnt_arr [NUM_RULES];

  // Address and data are taken together, one write in flight
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign rd_accept = arvalid && !rvalid;
  assign arready   = !rvalid;
  assign bresp     = RESP_OKAY;
  assign rresp     = RESP_OKAY;

  assign cnt_arr[RULE_RS_RESET]  = cnt_rs_reset;
  assign cnt_arr[RULE_DBG_CAUSE] = cnt_dbg_cause;
  assign cnt_arr[RULE_EXC_CAUSE] = cnt_exc_cause;
  assign cnt_arr[RULE_IRQ_CAUSE] = cnt_irq_cause;
  assign cnt_arr[RULE_NO_CAUSE]  = cnt_no_cause;
  assign cnt_arr[RULE_MEM_COUNT] = cnt_mem_count;

  always_comb begin
    rd_mux = 32'd0;
    case (araddr)
      REG_CTRL:   rd_mux = {31'd0, clic_en};
      REG_STATUS: rd_mux = {{(32-NUM_RULES){1'b0}}, status};
      REG_CNT0:   rd_mux = {{(32-CNT_W){1'b0}}, cnt_arr[RULE_RS_RESET]};
      REG_CNT1:   rd_mux = {{(32-CNT_W){1'b0}}, cnt_arr[RULE_DBG_CAUSE]};
      REG_CNT2:   rd_mux = {{(32-CNT_W){1'b0}}, cnt_arr[RULE_EXC_CAUSE]};
      REG_CNT3:   rd_mux = {{(32-CNT_W){1'b0}}, cnt_arr[RULE_IRQ_CAUSE]};
      REG_CNT4:   rd_mux = {{(32-CNT_W){1'b0}}, cnt_arr[RULE_NO_CAUSE]};
      REG_CNT5:   rd_mux = {{(32-CNT_W){1'b0}}, cnt_arr[RULE_MEM_COUNT]};
      default:    rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      clic_en <= 1'b0;
      clear   <= 1'b0;
    end else begin
      clear <= 1'b0;
      if (wr_accept) begin
        bvalid <= 1'b1;
        // Only CTRL is writable, the clear bit reads back as zero
        if ((awaddr == REG_CTRL) && wstrb[0]) begin
          clic_en <= wdata[0];
          clear   <= wdata[1];
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_accept) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata <= rd_mux;
    end
  end

endmodule

// File: rvfi_mon_top.sv
//******************************
// RVFI monitor top
//******************************

`timescale 1ns/1ps

module rvfi_mon_top import rvfi_mon_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rvfi_valid,
  input  logic [4:0]        rvfi_rs1_addr,
  input  logic [4:0]        rvfi_rs2_addr,
  input  logic [31:0]       rvfi_rs1_rdata,
  input  logic [31:0]       rvfi_rs2_rdata,
  input  logic [2:0]        rvfi_dbg,
  input  logic              rvfi_dbg_mode,
  input  logic [31:0]       rvfi_csr_dcsr_rdata,
  input  logic [31:0]       rvfi_csr_mcause_wdata,
  input  logic [31:0]       rvfi_csr_mcause_wmask,
  input  logic              rvfi_exception,
  input  logic [5:0]        rvfi_exception_cause,
  input  logic              rvfi_trap_debug,
  input  logic [2:0]        rvfi_debug_cause,
  input  logic              rvfi_intr,
  input  logic [10:0]       rvfi_intr_cause,
  input  logic [3:0]        rvfi_mem_rmask,
  input  logic [3:0]        rvfi_mem_wmask,
  input  logic              wbuf_valid,
  input  logic              wbuf_ready,
  input  logic              awvalid,
  output logic              awready,
  input  logic [AXI_AW-1:0] awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  output logic              bvalid,
  input  logic              bready,
  output logic [1:0]        bresp,
  input  logic              arvalid,
  output logic              arready,
  input  logic [AXI_AW-1:0] araddr,
  output logic              rvalid,
  input  logic              rready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              violation_o
);

  logic viol_rs_reset, viol_dbg_cause, viol_exc_cause;
  logic viol_irq_cause, viol_no_cause, viol_mem_count;
  logic clic_en;
  logic clear;
  logic [NUM_RULES-1:0] status;
  logic [CNT_W-1:0] cnt_rs_reset, cnt_dbg_cause, cnt_exc_cause;
  logic [CNT_W-1:0] cnt_irq_cause, cnt_no_cause, cnt_mem_count;

  retire_state_check i_retire_state_check (
    .clk_i, .rst_ni, .rvfi_valid, .rvfi_rs1_addr, .rvfi_rs2_addr,
    .rvfi_rs1_rdata, .rvfi_rs2_rdata, .rvfi_dbg, .rvfi_dbg_mode,
    .rvfi_csr_dcsr_rdata, .viol_rs_reset, .viol_dbg_cause
  );

  trap_cause_check i_trap_cause_check (
    .clk_i, .rst_ni, .clic_en, .rvfi_valid, .rvfi_dbg_mode, .rvfi_exception,
    .rvfi_exception_cause, .rvfi_csr_mcause_wdata, .rvfi_csr_mcause_wmask,
    .rvfi_intr, .rvfi_intr_cause, .rvfi_trap_debug, .rvfi_debug_cause,
    .viol_exc_cause, .viol_irq_cause, .viol_no_cause
  );

  mem_count_check i_mem_count_check (
    .clk_i, .rst_ni, .clear, .rvfi_valid, .rvfi_mem_rmask, .rvfi_mem_wmask,
    .wbuf_valid, .wbuf_ready, .viol_mem_count
  );

  violation_log i_violation_log (
    .clk_i, .rst_ni, .clear, .viol_rs_reset, .viol_dbg_cause, .viol_exc_cause,
    .viol_irq_cause, .viol_no_cause, .viol_mem_count, .cnt_rs_reset,
    .cnt_dbg_cause, .cnt_exc_cause, .cnt_irq_cause, .cnt_no_cause,
    .cnt_mem_count, .status, .violation_o
  );

  axil_regs i_axil_regs (
    .clk_i, .rst_ni, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
    .wstrb, .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .rvalid,
    .rready, .rdata, .rresp, .status, .cnt_rs_reset, .cnt_dbg_cause,
    .cnt_exc_cause, .cnt_irq_cause, .cnt_no_cause, .cnt_mem_count,
    .clic_en, .clear
  );

endmodule

// File: tb_clk_gen.sv
//******************************
// Testbench clock and reset
//******************************

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_i,
  output logic rst_ni
);

  localparam int PERIOD_NS  = 100;
  localparam int RST_CYCLES = 16;

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD_NS / 2) clk_i = ~clk_i;
  end

  // Release lines up with the stimulus drive point
  initial begin
    rst_ni = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #(PERIOD_NS / 10);
    rst_ni = 1'b1;
  end

endmodule

// File: tb_checker.sv
//******************************
// Testbench result checker
//******************************

`timescale 1ns/1ps

module tb_checker import rvfi_mon_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              awready,
  input  logic              wready,
  input  logic              bvalid,
  input  logic              bready,
  input  logic [1:0]        bresp,
  input  logic              rvalid,
  input  logic              rready,
  input  logic [31:0]       rdata,
  input  logic [1:0]        rresp,
  input  logic [AXI_AW-1:0] rd_addr,
  input  logic [31:0]       exp_rdata,
  input  logic              violation_o,
  input  logic              exp_violation,
  output int                err_cnt
);

  function automatic string reg_name(input logic [AXI_AW-1:0] addr);
    case (addr)
      REG_CTRL:   return "REG_CTRL";
      REG_STATUS: return "REG_STATUS";
      REG_CNT0:   return "REG_CNT0";
      REG_CNT1:   return "REG_CNT1";
      REG_CNT2:   return "REG_CNT2";
      REG_CNT3:   return "REG_CNT3";
      REG_CNT4:   return "REG_CNT4";
      REG_CNT5:   return "REG_CNT5";
      default:    return $sformatf("unmapped_0x%02h", addr);
    endcase
  endfunction

  initial err_cnt = 0;

  // Sampled at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (violation_o !== exp_violation) begin
        $display("FAILED time=%0t violation_o expected=%0b actual=%0b",
                 $time, exp_violation, violation_o);
        err_cnt = err_cnt + 1;
      end
      // Address and data channels accept together
      if (wready !== awready) begin
        $display("FAILED time=%0t wready expected=%0b actual=%0b", $time, awready, wready);
        err_cnt = err_cnt + 1;
      end
      if (bvalid && bready && (bresp !== RESP_OKAY)) begin
        $display("FAILED time=%0t bresp expected=%0d actual=%0d", $time, RESP_OKAY, bresp);
        err_cnt = err_cnt + 1;
      end
      if (rvalid && rready) begin
        if (rdata !== exp_rdata) begin
          $display("FAILED time=%0t %s expected=0x%08h actual=0x%08h",
                   $time, reg_name(rd_addr), exp_rdata, rdata);
          err_cnt = err_cnt + 1;
        end
        if (rresp !== RESP_OKAY) begin
          $display("FAILED time=%0t rresp expected=%0d actual=%0d", $time, RESP_OKAY, rresp);
          err_cnt = err_cnt + 1;
        end
      end
    end
  end

endmodule

// File: tb_rvfi_mon.sv
//******************************
// RVFI monitor testbench
//******************************

`timescale 1ns/1ps

module tb_rvfi_mon import rvfi_mon_pkg::*;;

  localparam int     CLK_PERIOD_NS = 100;
  localparam int     DRIVE_DLY     = 10;
  localparam int     STIM_CYCLES   = 16 + 2 + 100 + 300 + 300 + 300 + 200 + 60;
  localparam int     NUM_XFERS     = 9 * 8 + 7;
  localparam int     XFER_CYCLES   = 10;
  localparam longint WATCHDOG_NS   = 2 * (STIM_CYCLES + NUM_XFERS * XFER_CYCLES) * CLK_PERIOD_NS;

  logic clk_i, rst_ni;
  logic rvfi_valid, rvfi_dbg_mode, rvfi_exception, rvfi_trap_debug, rvfi_intr;
  logic [4:0]  rvfi_rs1_addr, rvfi_rs2_addr;
  logic [31:0] rvfi_rs1_rdata, rvfi_rs2_rdata, rvfi_csr_dcsr_rdata;
  logic [31:0] rvfi_csr_mcause_wdata, rvfi_csr_mcause_wmask;
  logic [2:0]  rvfi_dbg, rvfi_debug_cause;
  logic [5:0]  rvfi_exception_cause;
  logic [10:0] rvfi_intr_cause;
  logic [3:0]  rvfi_mem_rmask, rvfi_mem_wmask, wstrb;
  logic wbuf_valid, wbuf_ready;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, violation_o;
  logic [AXI_AW-1:0] awaddr, araddr, rd_addr;
  logic [31:0] wdata, rdata, exp_rdata;
  logic [1:0]  bresp, rresp;
  logic        exp_violation;
  int          err_cnt;

  // Reference model state
  logic [CNT_W-1:0]     m_cnt [NUM_RULES];
  logic [NUM_RULES-1:0] m_status, m_pend, pulse;
  logic                 m_first, m_was_dbg, m_clic, m_clear;
  logic [31:0]          m_bus, m_ret;
  logic [31:0]          lcg_state = 32'd25;

  tb_clk_gen   i_clk_gen (.*);
  rvfi_mon_top i_dut (.*);
  tb_checker   i_checker (.*);

  assign exp_violation = |m_status;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return (lcg_next() >> 8) % n;
  endfunction

  function automatic logic irq_legal(input logic [10:0] cause, input logic clic);
    if ((cause >= 11'd1024) && (cause <= 11'd1027)) begin
      return 1'b1;
    end
    if (clic) begin
      return cause <= 11'd31;
    end
    return (cause == 11'd3) || (cause == 11'd7) || (cause == 11'd11) ||
           ((cause >= 11'd16) && (cause <= 11'd31));
  endfunction

  function automatic logic [31:0] reg_value(input logic [AXI_AW-1:0] addr);
    if (addr == 6'h00) begin
      return {31'd0, m_clic};
    end
    if (addr == 6'h04) begin
      return {26'd0, m_status};
    end
    // Counters sit at 0x08 onwards in rule order
    if ((addr >= 6'h08) && (addr <= 6'h1C) && (addr[1:0] == 2'b00)) begin
      return {16'd0, m_cnt[(addr - 6'h08) >> 2]};
    end
    return 32'd0;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_RULES; i++) begin
        m_cnt[i] = '0;
      end
      m_status  = '0;
      m_pend    = '0;
      m_first   = 1'b1;
      m_was_dbg = 1'b0;
      m_clic    = 1'b0;
      m_clear   = 1'b0;
      m_bus     = 32'd0;
      m_ret     = 32'd0;
      rd_addr   = '0;
      exp_rdata = 32'd0;
    end else begin
      // Read data reflects the state before this edge
      if (arvalid && arready) begin
        rd_addr   = araddr;
        exp_rdata = reg_value(araddr);
      end
      pulse = '0;
      if (rvfi_valid) begin
        pulse[RULE_RS_RESET] = m_first &&
          (((rvfi_rs1_addr != 5'd0) && (rvfi_rs1_rdata != 32'd0)) ||
           ((rvfi_rs2_addr != 5'd0) && (rvfi_rs2_rdata != 32'd0)));
        pulse[RULE_DBG_CAUSE] = (rvfi_dbg != 3'd0) && !m_was_dbg &&
                                (rvfi_dbg != rvfi_csr_dcsr_rdata[8:6]);
        pulse[RULE_EXC_CAUSE] = rvfi_exception && !rvfi_dbg_mode &&
          ({5'd0, rvfi_exception_cause} !=
           (rvfi_csr_mcause_wdata[10:0] & rvfi_csr_mcause_wmask[10:0]));
        pulse[RULE_IRQ_CAUSE] = rvfi_intr && !irq_legal(rvfi_intr_cause, m_clic);
        pulse[RULE_NO_CAUSE]  = (rvfi_exception && (rvfi_exception_cause == 6'd0)) ||
                                (rvfi_trap_debug && (rvfi_debug_cause == 3'd0)) ||
                                (rvfi_intr && !m_clic && (rvfi_intr_cause == 11'd0));
      end
      pulse[RULE_MEM_COUNT] = !m_clear && (m_ret > m_bus);
      for (int i = 0; i < NUM_RULES; i++) begin
        if (m_clear) begin
          m_cnt[i] = '0;
        end else if (m_pend[i] && (m_cnt[i] != '1)) begin
          m_cnt[i] = m_cnt[i] + 1'b1;
        end
      end
      m_status = m_clear ? '0 : (m_status | m_pend);
      m_pend   = pulse;
      if (m_clear) begin
        m_bus = 32'd0;
        m_ret = 32'd0;
      end else begin
        m_bus = m_bus + (wbuf_valid && wbuf_ready);
        if (rvfi_valid) begin
          m_ret = m_ret + (rvfi_mem_rmask != 4'd0) + (rvfi_mem_wmask != 4'd0);
        end
      end
      if (rvfi_valid) begin
        m_first   = 1'b0;
        m_was_dbg = rvfi_dbg_mode;
      end
      m_clear = 1'b0;
      if (awvalid && wvalid && awready && (awaddr == 6'h00) && wstrb[0]) begin
        m_clic  = wdata[0];
        m_clear = wdata[1];
      end
    end
  end

  task automatic init_inputs();
    {rvfi_valid, rvfi_dbg_mode, rvfi_exception, rvfi_trap_debug, rvfi_intr} = '0;
    {rvfi_rs1_addr, rvfi_rs2_addr, rvfi_rs1_rdata, rvfi_rs2_rdata} = '0;
    {rvfi_dbg, rvfi_csr_dcsr_rdata, rvfi_csr_mcause_wdata, rvfi_csr_mcause_wmask} = '0;
    {rvfi_exception_cause, rvfi_debug_cause, rvfi_intr_cause} = '0;
    {rvfi_mem_rmask, rvfi_mem_wmask, wbuf_valid, wbuf_ready} = '0;
    {awvalid, awaddr, wvalid, wdata, wstrb, arvalid, araddr} = '0;
    bready = 1'b1;
    rready = 1'b1;
  endtask

  task automatic random_cycle(input int unsigned bus_pct);
    rvfi_valid     = rand_below(10) < 6;
    rvfi_rs1_addr  = rand_below(32);
    rvfi_rs2_addr  = rand_below(32);
    rvfi_rs1_rdata = (rand_below(4) == 0) ? 32'd0 : lcg_next();
    rvfi_rs2_rdata = (rand_below(4) == 0) ? 32'd0 : lcg_next();
    rvfi_dbg       = (rand_below(4) == 0) ? rand_below(5) : 0;
    rvfi_dbg_mode  = rand_below(4) == 0;
    rvfi_csr_dcsr_rdata = lcg_next();
    if (rand_below(2) == 0) begin
      rvfi_csr_dcsr_rdata[8:6] = rvfi_dbg;
    end
    rvfi_exception       = rand_below(5) == 0;
    rvfi_exception_cause = (rand_below(8) == 0) ? 0 : rand_below(64);
    rvfi_csr_mcause_wdata = lcg_next();
    if (rand_below(2) == 0) begin
      rvfi_csr_mcause_wdata[10:0] = {5'd0, rvfi_exception_cause};
    end
    rvfi_csr_mcause_wmask = (rand_below(3) == 0) ? lcg_next() : 32'hFFFF_FFFF;
    rvfi_intr = rand_below(5) == 0;
    case (rand_below(6))
      0:       rvfi_intr_cause = 11'd0;
      1:       rvfi_intr_cause = 11'd3 + 11'd4 * rand_below(3);
      2:       rvfi_intr_cause = 11'd16 + rand_below(16);
      3:       rvfi_intr_cause = rand_below(32);
      4:       rvfi_intr_cause = 11'd1022 + rand_below(8);
      default: rvfi_intr_cause = rand_below(2048);
    endcase
    rvfi_trap_debug  = rand_below(8) == 0;
    rvfi_debug_cause = rand_below(8);
    rvfi_mem_rmask   = (rand_below(4) == 0) ? rand_below(16) : 0;
    rvfi_mem_wmask   = (rand_below(4) == 0) ? rand_below(16) : 0;
    wbuf_valid       = rand_below(100) < bus_pct;
    wbuf_ready       = rand_below(4) != 0;
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic random_phase(input int cycles, input int unsigned bus_pct);
    repeat (cycles) random_cycle(bus_pct);
    rvfi_valid = 1'b0;
    wbuf_valid = 1'b0;
  endtask

  task automatic retire_rs(input logic [4:0] addr, input logic [31:0] data);
    rvfi_valid     = 1'b1;
    rvfi_rs1_addr  = addr;
    rvfi_rs1_rdata = data;
    @(posedge clk_i);
    #DRIVE_DLY;
    rvfi_valid = 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_AW-1:0] addr, input int stall);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (stall == 0);
    @(posedge clk_i);
    while (!arready) @(posedge clk_i);
    #DRIVE_DLY;
    arvalid = 1'b0;
    if (stall > 0) begin
      repeat (stall) @(posedge clk_i);
      #DRIVE_DLY;
      rready = 1'b1;
    end
    @(posedge clk_i);
    while (!(rvalid && rready)) @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [31:0] data,
                           input int stall);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (stall == 0);
    @(posedge clk_i);
    while (!awready) @(posedge clk_i);
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (stall > 0) begin
      repeat (stall) @(posedge clk_i);
      #DRIVE_DLY;
      bready = 1'b1;
    end
    @(posedge clk_i);
    while (!(bvalid && bready)) @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic read_all();
    for (int a = 0; a < 8; a++) begin
      axi_read(a * 4, 0);
    end
  endtask

  initial begin
    init_inputs();
    wait (rst_ni);
    @(posedge clk_i);
    #DRIVE_DLY;
    read_all();
    // Only the first retirement is checked against reset values
    retire_rs(5'd5, 32'h0000_1234);
    retire_rs(5'd9, 32'hDEAD_BEEF);
    read_all();
    random_phase(100, 50);
    read_all();
    random_phase(300, 50);
    read_all();
    // CLIC mode
    axi_write(REG_CTRL, 32'h1, 0);
    random_phase(300, 50);
    read_all();
    // Bus requests lag behind retirements
    random_phase(300, 20);
    read_all();
    axi_write(REG_CTRL, 32'h3, 0);
    read_all();
    random_phase(200, 50);
    read_all();
    fork
      random_phase(60, 40);
      begin
        axi_read(REG_CNT5, 6);
        axi_write(REG_CTRL, 32'h0, 5);
        axi_read(6'h20, 3);
      end
    join
    axi_read(6'h3C, 0);
    axi_read(6'h02, 0);
    read_all();
    @(posedge clk_i);
    $display("Checks done, error count %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the test sequence did not complete", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: build.f
rvfi_mon_pkg.sv
retire_state_check.sv
trap_cause_check.sv
mem_count_check.sv
violation_log.sv
axil_regs.sv
rvfi_mon_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_rvfi_mon.sv
